/* src/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

	// instruction field positions
	localparam int OP_MSB    = 31;
	localparam int OP_LSB    = 26;
	localparam int RS_MSB    = 25;
	localparam int RS_LSB    = 21;
	localparam int RT_MSB    = 20;
	localparam int RT_LSB    = 16;
	localparam int SHAMT_MSB = 10;
	localparam int SHAMT_LSB = 6;
	localparam int FUNCT_MSB = 5;
	localparam int FUNCT_LSB = 0;
	localparam int IMM_MSB   = 15;
	localparam int IMM_LSB   = 0;

	// primary opcodes handled by the slice
	typedef enum logic [5:0] {
		OP_SPECIAL  = 6'b000000,
		OP_REGIMM   = 6'b000001,
		OP_BEQ      = 6'b000100,
		OP_BNE      = 6'b000101,
		OP_BLEZ     = 6'b000110,
		OP_BGTZ     = 6'b000111,
		OP_ADDI     = 6'b001000,
		OP_ADDIU    = 6'b001001,
		OP_SLTI     = 6'b001010,
		OP_SLTIU    = 6'b001011,
		OP_ANDI     = 6'b001100,
		OP_ORI      = 6'b001101,
		OP_XORI     = 6'b001110,
		OP_LUI      = 6'b001111,
		OP_SPECIAL2 = 6'b011100,
		OP_LB       = 6'b100000,
		OP_LH       = 6'b100001,
		OP_LW       = 6'b100011,
		OP_LBU      = 6'b100100,
		OP_LHU      = 6'b100101,
		OP_SB       = 6'b101000,
		OP_SH       = 6'b101001,
		OP_SW       = 6'b101011
	} opcode_e;

	// SPECIAL (R-type) function codes
	typedef enum logic [5:0] {
		FN_SLL   = 6'b000000,
		FN_SRL   = 6'b000010,
		FN_SRA   = 6'b000011,
		FN_SLLV  = 6'b000100,
		FN_SRLV  = 6'b000110,
		FN_SRAV  = 6'b000111,
		FN_MTHI  = 6'b010001,
		FN_MTLO  = 6'b010011,
		FN_MULT  = 6'b011000,
		FN_MULTU = 6'b011001,
		FN_DIV   = 6'b011010,
		FN_DIVU  = 6'b011011,
		FN_ADD   = 6'b100000,
		FN_ADDU  = 6'b100001,
		FN_SUB   = 6'b100010,
		FN_SUBU  = 6'b100011,
		FN_AND   = 6'b100100,
		FN_OR    = 6'b100101,
		FN_XOR   = 6'b100110,
		FN_NOR   = 6'b100111,
		FN_SLT   = 6'b101010,
		FN_SLTU  = 6'b101011
	} funct_e;

	// MUL function code under SPECIAL2, same value as SRL
	localparam logic [5:0] FUNCT_MUL = 6'b000010;

	// REGIMM branches, selected by the rt field
	typedef enum logic [4:0] {
		RT_BLTZ   = 5'b00000,
		RT_BGEZ   = 5'b00001,
		RT_BLTZAL = 5'b10000,
		RT_BGEZAL = 5'b10001
	} regimm_e;

endpackage

`default_nettype wire

/* src/alu_ctrl_pkg.sv */
`default_nettype none

package alu_ctrl_pkg;

	localparam int DATA_W  = 32;
	localparam int SHAMT_W = 5;

	typedef enum logic [4:0] {
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_ADD,
		ALU_ADDU,
		ALU_SUB,
		ALU_SUBU,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL_SA,
		ALU_SRL_SA,
		ALU_SRA_SA,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI,
		ALU_MUL,
		ALU_MULT,
		ALU_MULTU,
		ALU_MTHI,
		ALU_MTLO,
		ALU_NOP
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_GTZ,
		BR_LEZ,
		BR_LTZ,
		BR_GEZ
	} br_cond_e;

	// one instruction entering the slice
	typedef struct packed {
		logic [DATA_W-1:0] instr;
		logic [DATA_W-1:0] rs_value;
		logic [DATA_W-1:0] rt_value;
	} issue_t;

	// decoded instruction in the execute register
	typedef struct packed {
		alu_op_e            op;
		br_cond_e           cond;
		logic [DATA_W-1:0]  a;
		// rt value or extended immediate
		logic [DATA_W-1:0]  b;
		logic [SHAMT_W-1:0] shamt;
		logic [DATA_W-1:0]  rt_value;
	} exec_t;

	// one completed instruction
	typedef struct packed {
		logic [DATA_W-1:0] result;
		logic [DATA_W-1:0] hi;
		logic [DATA_W-1:0] lo;
		logic              overflow;
		logic              branch_taken;
		// set by MULT/MULTU/MTHI
		logic              writes_hi;
		// set by MULT/MULTU/MTLO
		logic              writes_lo;
	} result_t;

endpackage

`default_nettype wire

/* src/alu_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_decoder
	import mips_isa_pkg::*;
	import alu_ctrl_pkg::*;
(
	input  wire logic [31:0] instr,
	input  wire logic [31:0] rs_value,
	input  wire logic [31:0] rt_value,
	output exec_t            dec
);

	opcode_e     op_code;
	funct_e      funct;
	regimm_e     rt_field;
	logic [15:0] imm;
	logic [31:0] imm_sext;
	logic [31:0] imm_zext;

	assign op_code  = opcode_e'(instr[OP_MSB:OP_LSB]);
	assign funct    = funct_e'(instr[FUNCT_MSB:FUNCT_LSB]);
	assign rt_field = regimm_e'(instr[RT_MSB:RT_LSB]);
	assign imm      = instr[IMM_MSB:IMM_LSB];
	assign imm_sext = {{16{imm[15]}}, imm};
	assign imm_zext = {16'b0, imm};

	always_comb begin
		dec.op       = ALU_NOP;
		dec.cond     = BR_NONE;
		dec.a        = rs_value;
		dec.b        = rt_value;
		dec.shamt    = instr[SHAMT_MSB:SHAMT_LSB];
		dec.rt_value = rt_value;

		case (op_code)
			OP_SPECIAL: begin
				case (funct)
					FN_AND:   dec.op = ALU_AND;
					FN_OR:    dec.op = ALU_OR;
					FN_XOR:   dec.op = ALU_XOR;
					FN_NOR:   dec.op = ALU_NOR;
					FN_ADD:   dec.op = ALU_ADD;
					FN_SUB:   dec.op = ALU_SUB;
					FN_ADDU:  dec.op = ALU_ADDU;
					FN_SUBU:  dec.op = ALU_SUBU;
					FN_SLT:   dec.op = ALU_SLT;
					FN_SLTU:  dec.op = ALU_SLTU;
					FN_MULT:  dec.op = ALU_MULT;
					FN_MULTU: dec.op = ALU_MULTU;
					// no divider in this slice
					FN_DIV:   dec.op = ALU_NOP;
					FN_DIVU:  dec.op = ALU_NOP;
					// shamt forms
					FN_SLL:   dec.op = ALU_SLL_SA;
					FN_SRL:   dec.op = ALU_SRL_SA;
					FN_SRA:   dec.op = ALU_SRA_SA;
					// register forms
					FN_SLLV:  dec.op = ALU_SLL;
					FN_SRLV:  dec.op = ALU_SRL;
					FN_SRAV:  dec.op = ALU_SRA;
					FN_MTHI:  dec.op = ALU_MTHI;
					FN_MTLO:  dec.op = ALU_MTLO;
					default:  dec.op = ALU_NOP;
				endcase
			end
			// arithmetic immediates are sign extended
			OP_ADDI:  begin dec.op = ALU_ADD;  dec.b = imm_sext; end
			OP_ADDIU: begin dec.op = ALU_ADDU; dec.b = imm_sext; end
			OP_SLTI:  begin dec.op = ALU_SLT;  dec.b = imm_sext; end
			OP_SLTIU: begin dec.op = ALU_SLTU; dec.b = imm_sext; end
			// logic immediates are zero extended
			OP_ANDI:  begin dec.op = ALU_AND;  dec.b = imm_zext; end
			OP_ORI:   begin dec.op = ALU_OR;   dec.b = imm_zext; end
			OP_XORI:  begin dec.op = ALU_XOR;  dec.b = imm_zext; end
			// shifted into the upper half by the ALU
			OP_LUI:   begin dec.op = ALU_LUI;  dec.b = imm_zext; end
			// address = base + offset
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW: begin
				dec.op = ALU_ADDU;
				dec.b  = imm_sext;
			end
			OP_SPECIAL2: begin
				if (instr[FUNCT_MSB:FUNCT_LSB] == FUNCT_MUL) begin
					dec.op = ALU_MUL;
				end
			end
			OP_BEQ:  dec.cond = BR_EQ;
			OP_BNE:  dec.cond = BR_NE;
			OP_BLEZ: dec.cond = BR_LEZ;
			OP_BGTZ: dec.cond = BR_GTZ;
			OP_REGIMM: begin
				case (rt_field)
					RT_BLTZ, RT_BLTZAL: dec.cond = BR_LTZ;
					RT_BGEZ, RT_BGEZAL: dec.cond = BR_GEZ;
					default:            dec.cond = BR_NONE;
				endcase
			end
			default: begin
				dec.op   = ALU_NOP;
				dec.cond = BR_NONE;
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/alu_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_execute
	import alu_ctrl_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic in_valid,
	output logic      in_ready,
	input  exec_t     dec,
	output logic      x_valid,
	input  wire logic x_ready,
	output result_t   x_result
);

	exec_t        ex_q;
	logic         ex_valid;
	logic [31:0]  a;
	logic [31:0]  b;
	logic [31:0]  sum;
	logic [31:0]  diff;
	logic         mul_signed;
	logic [63:0]  mul_a;
	logic [63:0]  mul_b;
	logic [63:0]  prod;
	logic [31:0]  res;
	logic         ovf;
	logic         taken;

	// free when empty or drained this cycle
	assign in_ready = !ex_valid || x_ready;
	assign x_valid  = ex_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
		end else if (in_valid && in_ready) begin
			ex_valid <= 1'b1;
		end else if (x_ready) begin
			ex_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			ex_q <= dec;
		end
	end

	assign a    = ex_q.a;
	assign b    = ex_q.b;
	assign sum  = a + b;
	assign diff = a - b;

	// one multiplier covers MULT, MULTU and MUL
	// operands sign or zero extended to the full product width
	assign mul_signed = (ex_q.op != ALU_MULTU);
	assign mul_a      = {{32{mul_signed & a[31]}}, a};
	assign mul_b      = {{32{mul_signed & b[31]}}, b};
	assign prod       = mul_a * mul_b;

	always_comb begin
		res = '0;
		ovf = 1'b0;
		case (ex_q.op)
			ALU_AND:    res = a & b;
			ALU_OR:     res = a | b;
			ALU_XOR:    res = a ^ b;
			ALU_NOR:    res = ~(a | b);
			ALU_ADD: begin
				res = sum;
				ovf = (a[31] == b[31]) && (sum[31] != a[31]);
			end
			ALU_ADDU:   res = sum;
			ALU_SUB: begin
				res = diff;
				ovf = (a[31] != b[31]) && (diff[31] != a[31]);
			end
			ALU_SUBU:   res = diff;
			ALU_SLT:    res = {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU:   res = {31'b0, a < b};
			ALU_SLL_SA: res = b << ex_q.shamt;
			ALU_SRL_SA: res = b >> ex_q.shamt;
			ALU_SRA_SA: res = $signed(b) >>> ex_q.shamt;
			ALU_SLL:    res = b << a[4:0];
			ALU_SRL:    res = b >> a[4:0];
			ALU_SRA:    res = $signed(b) >>> a[4:0];
			ALU_LUI:    res = {b[15:0], 16'b0};
			ALU_MUL:    res = prod[31:0];
			// hi/lo writers and NOP leave the result at zero
			default:    res = '0;
		endcase
	end

	// branch judgement
	always_comb begin
		case (ex_q.cond)
			BR_EQ:   taken = (a == ex_q.rt_value);
			BR_NE:   taken = (a != ex_q.rt_value);
			BR_GTZ:  taken = !a[31] && (a != '0);
			BR_LEZ:  taken = a[31] || (a == '0);
			BR_LTZ:  taken = a[31];
			BR_GEZ:  taken = !a[31];
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		x_result.result       = res;
		x_result.overflow     = ovf;
		x_result.branch_taken = taken;
		x_result.hi           = prod[63:32];
		x_result.lo           = prod[31:0];
		x_result.writes_hi    = 1'b0;
		x_result.writes_lo    = 1'b0;
		case (ex_q.op)
			ALU_MULT, ALU_MULTU: begin
				x_result.writes_hi = 1'b1;
				x_result.writes_lo = 1'b1;
			end
			ALU_MTHI: begin
				x_result.hi        = a;
				x_result.writes_hi = 1'b1;
			end
			ALU_MTLO: begin
				x_result.lo        = a;
				x_result.writes_lo = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* src/alu_result.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_result
	import alu_ctrl_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic x_valid,
	output logic      x_ready,
	input  result_t   x_result,
	output logic      out_valid,
	input  wire logic out_ready,
	output result_t   out_data
);

	logic [31:0] hi_q;
	logic [31:0] lo_q;
	logic [31:0] hi_next;
	logic [31:0] lo_next;
	logic        load;
	result_t     out_q;
	logic        out_valid_q;

	assign x_ready = !out_valid_q || out_ready;
	assign load    = x_valid && x_ready;

	// only the halves named by the instruction change
	assign hi_next = x_result.writes_hi ? x_result.hi : hi_q;
	assign lo_next = x_result.writes_lo ? x_result.lo : lo_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			hi_q <= '0;
			lo_q <= '0;
		end else if (load) begin
			hi_q <= hi_next;
			lo_q <= lo_next;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid_q <= 1'b0;
		end else if (load) begin
			out_valid_q <= 1'b1;
		end else if (out_ready) begin
			out_valid_q <= 1'b0;
		end
	end

	// bundle shows the pair as it stands after this instruction
	always_ff @(posedge clk) begin
		if (load) begin
			out_q    <= x_result;
			out_q.hi <= hi_next;
			out_q.lo <= lo_next;
		end
	end

	assign out_valid = out_valid_q;
	assign out_data  = out_q;

endmodule

`default_nettype wire

/* src/alu_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_subsystem
	import alu_ctrl_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic in_valid,
	output logic      in_ready,
	input  issue_t    in_data,
	output logic      out_valid,
	input  wire logic out_ready,
	output result_t   out_data
);

	exec_t   dec;
	logic    x_valid;
	logic    x_ready;
	result_t x_result;

	alu_decoder decoder_i (
		.instr    (in_data.instr),
		.rs_value (in_data.rs_value),
		.rt_value (in_data.rt_value),
		.dec      (dec)
	);

	alu_execute execute_i (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.dec      (dec),
		.x_valid  (x_valid),
		.x_ready  (x_ready),
		.x_result (x_result)
	);

	alu_result result_i (
		.clk       (clk),
		.rst       (rst),
		.x_valid   (x_valid),
		.x_ready   (x_ready),
		.x_result  (x_result),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk
);

	// 4 ns period
	localparam int HALF_PERIOD = 2;

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD clk = ~clk;
		end
	end

endmodule

`default_nettype wire

/* tb/alu_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_subsystem_tb
	import mips_isa_pkg::*;
	import alu_ctrl_pkg::*;
();

	localparam int unsigned SEED = 38254;

	localparam int N_RESET     = 3;
	localparam int N_ARITH     = 120;
	localparam int N_OVF       = 24;
	localparam int N_BRANCH    = 32;
	localparam int N_UNDEF     = 8;
	localparam int N_HILO      = 40;
	localparam int N_MIXED     = 150;
	localparam int N_TOTAL     = N_RESET + N_ARITH + N_OVF + N_BRANCH + N_UNDEF
		+ N_HILO + N_MIXED;
	localparam int CYCLE_LIMIT = 4 * N_TOTAL + 100;

	localparam int T_RESET  = 0;
	localparam int T_ARITH  = 1;
	localparam int T_OVF    = 2;
	localparam int T_BRANCH = 3;
	localparam int T_HILO   = 4;
	localparam int T_BACKPR = 5;

	localparam logic [5:0] ARITH_FN [16] = '{FN_AND, FN_OR, FN_XOR, FN_NOR, FN_ADD,
		FN_SUB, FN_ADDU, FN_SUBU, FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV,
		FN_SRLV, FN_SRAV};
	localparam logic [5:0] IMM_OP [10] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
		OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW};

	logic    clk;
	logic    rst;
	logic    in_valid;
	logic    in_ready;
	issue_t  in_data;
	logic    out_valid;
	logic    out_ready;
	result_t out_data;

	// stimulus side state, sampled by the monitor at the edge
	logic bp_mode;
	logic lat_check;
	int   in_id;
	int   cur_test;

	// reference model
	logic [31:0] model_hi;
	logic [31:0] model_lo;
	result_t     model_q [$];
	int          id_q [$];
	int          cycle_q [$];
	bit          timed_q [$];
	int          cycle_count;

	tb_clock clock_i (
		.clk (clk)
	);

	alu_subsystem dut_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	function string test_name(input int id);
		case (id)
			T_RESET:  return "reset_state";
			T_ARITH:  return "arith_logic_shift";
			T_OVF:    return "overflow";
			T_BRANCH: return "branch";
			T_HILO:   return "hilo_order";
			default:  return "back_pressure";
		endcase
	endfunction

	task automatic end_with_failure();
		$display("TB FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_mismatch(input string test, input string expected,
		input string actual);
		$display("FAIL %s expected %s actual %s", test, expected, actual);
		end_with_failure();
	endtask

	task automatic report_error(input string msg);
		$display("ERROR %s", msg);
		end_with_failure();
	endtask

	// expected bundle from the ISA rules, hi/lo given as they stand before
	function automatic result_t predict(input logic [31:0] instr, input logic [31:0] rs,
		input logic [31:0] rt, input logic [31:0] hi, input logic [31:0] lo);
		result_t     r;
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [4:0]  sh;
		logic [4:0]  rtf;
		logic [31:0] simm;
		logic [32:0] wide;
		logic [63:0] p;
		r    = '0;
		r.hi = hi;
		r.lo = lo;
		op   = instr[31:26];
		fn   = instr[5:0];
		sh   = instr[10:6];
		rtf  = instr[20:16];
		simm = {{16{instr[15]}}, instr[15:0]};
		case (op)
			OP_SPECIAL: begin
				case (fn)
					FN_AND:  r.result = rs & rt;
					FN_OR:   r.result = rs | rt;
					FN_XOR:  r.result = rs ^ rt;
					FN_NOR:  r.result = ~(rs | rt);
					FN_ADDU: r.result = rs + rt;
					FN_SUBU: r.result = rs - rt;
					FN_ADD: begin
						wide       = {rs[31], rs} + {rt[31], rt};
						r.result   = wide[31:0];
						r.overflow = wide[32] ^ wide[31];
					end
					FN_SUB: begin
						wide       = {rs[31], rs} - {rt[31], rt};
						r.result   = wide[31:0];
						r.overflow = wide[32] ^ wide[31];
					end
					// signed compare by flipping the sign bits
					FN_SLT:  r.result = {31'b0, (rs ^ 32'h8000_0000) < (rt ^ 32'h8000_0000)};
					FN_SLTU: r.result = {31'b0, rs < rt};
					FN_SLL:  r.result = rt << sh;
					FN_SRL:  r.result = rt >> sh;
					FN_SRA: begin
						p        = {{32{rt[31]}}, rt} >> sh;
						r.result = p[31:0];
					end
					FN_SLLV: r.result = rt << rs[4:0];
					FN_SRLV: r.result = rt >> rs[4:0];
					FN_SRAV: begin
						p        = {{32{rt[31]}}, rt} >> rs[4:0];
						r.result = p[31:0];
					end
					FN_MULT: begin
						p           = {{32{rs[31]}}, rs} * {{32{rt[31]}}, rt};
						r.hi        = p[63:32];
						r.lo        = p[31:0];
						r.writes_hi = 1'b1;
						r.writes_lo = 1'b1;
					end
					FN_MULTU: begin
						p           = {32'b0, rs} * {32'b0, rt};
						r.hi        = p[63:32];
						r.lo        = p[31:0];
						r.writes_hi = 1'b1;
						r.writes_lo = 1'b1;
					end
					FN_MTHI: begin
						r.hi        = rs;
						r.writes_hi = 1'b1;
					end
					FN_MTLO: begin
						r.lo        = rs;
						r.writes_lo = 1'b1;
					end
					default: ;
				endcase
			end
			OP_ADDI: begin
				wide       = {rs[31], rs} + {simm[31], simm};
				r.result   = wide[31:0];
				r.overflow = wide[32] ^ wide[31];
			end
			OP_ADDIU: r.result = rs + simm;
			OP_SLTI:  r.result = {31'b0, (rs ^ 32'h8000_0000) < (simm ^ 32'h8000_0000)};
			OP_SLTIU: r.result = {31'b0, rs < simm};
			OP_ANDI:  r.result = rs & {16'b0, instr[15:0]};
			OP_ORI:   r.result = rs | {16'b0, instr[15:0]};
			OP_XORI:  r.result = rs ^ {16'b0, instr[15:0]};
			OP_LUI:   r.result = {instr[15:0], 16'b0};
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW: r.result = rs + simm;
			OP_SPECIAL2: begin
				if (fn == FUNCT_MUL) begin
					r.result = rs * rt;
				end
			end
			OP_BEQ:  r.branch_taken = (rs == rt);
			OP_BNE:  r.branch_taken = (rs != rt);
			OP_BLEZ: r.branch_taken = ($signed(rs) <= 0);
			OP_BGTZ: r.branch_taken = ($signed(rs) > 0);
			OP_REGIMM: begin
				if (rtf == RT_BLTZ || rtf == RT_BLTZAL) begin
					r.branch_taken = rs[31];
				end else if (rtf == RT_BGEZ || rtf == RT_BGEZAL) begin
					r.branch_taken = !rs[31];
				end
			end
			default: ;
		endcase
		return r;
	endfunction

	function logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] sh);
		return {OP_SPECIAL, 5'($urandom), 5'($urandom), 5'($urandom), sh, fn};
	endfunction

	function logic [31:0] i_type(input logic [5:0] op, input logic [15:0] imm);
		return {op, 5'($urandom), 5'($urandom), imm};
	endfunction

	function logic [31:0] arith_instr();
		if ($urandom % 2 == 0) begin
			return r_type(ARITH_FN[4'($urandom)], 5'($urandom));
		end
		return i_type(IMM_OP[4'($urandom % 10)], 16'($urandom));
	endfunction

	function logic [31:0] branch_instr(input logic [2:0] k);
		case (k)
			3'd0:    return i_type(OP_BEQ, 16'($urandom));
			3'd1:    return i_type(OP_BNE, 16'($urandom));
			3'd2:    return i_type(OP_BLEZ, 16'($urandom));
			3'd3:    return i_type(OP_BGTZ, 16'($urandom));
			3'd4:    return {OP_REGIMM, 5'($urandom), RT_BLTZ, 16'($urandom)};
			3'd5:    return {OP_REGIMM, 5'($urandom), RT_BGEZ, 16'($urandom)};
			3'd6:    return {OP_REGIMM, 5'($urandom), RT_BLTZAL, 16'($urandom)};
			default: return {OP_REGIMM, 5'($urandom), RT_BGEZAL, 16'($urandom)};
		endcase
	endfunction

	// encodings the slice does not execute
	function logic [31:0] odd_instr(input logic [2:0] k);
		case (k)
			3'd0:    return {6'b010000, 26'($urandom)};
			3'd1:    return {6'b111111, 26'($urandom)};
			3'd2:    return {6'b000010, 26'($urandom)};
			3'd3:    return r_type(FN_DIV, 5'd0);
			3'd4:    return r_type(FN_DIVU, 5'd0);
			3'd5:    return r_type(6'b001000, 5'd0);
			3'd6:    return {OP_SPECIAL2, 20'($urandom), 6'b000000};
			default: return {OP_REGIMM, 5'($urandom), 5'b00010, 16'($urandom)};
		endcase
	endfunction

	function logic [31:0] hilo_instr(input logic [2:0] k);
		case (k)
			3'd0:    return r_type(FN_MULT, 5'd0);
			3'd1:    return r_type(FN_MULTU, 5'd0);
			3'd2:    return r_type(FN_MTHI, 5'd0);
			3'd3:    return r_type(FN_MTLO, 5'd0);
			default: return {OP_SPECIAL2, 15'($urandom), 5'd0, FUNCT_MUL};
		endcase
	endfunction

	function logic [31:0] mixed_instr();
		case (2'($urandom))
			2'd0:    return arith_instr();
			2'd1:    return hilo_instr(3'($urandom % 5));
			2'd2:    return branch_instr(3'($urandom));
			default: return odd_instr(3'($urandom));
		endcase
	endfunction

	// called at a rising edge, returns at the edge of the transfer
	task automatic issue(input logic [31:0] instr, input logic [31:0] rs,
		input logic [31:0] rt);
		in_valid <= 1'b1;
		in_data  <= {instr, rs, rt};
		in_id    <= cur_test;
		@(posedge clk);
		while (!in_ready) begin
			@(posedge clk);
		end
		in_valid <= 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic drain();
		while (model_q.size() != 0) begin
			@(posedge clk);
		end
	endtask

	task automatic overflow_pair(input logic [31:0] a, input logic [31:0] b);
		issue(r_type(FN_ADD, 5'd0), a, b);
		issue(r_type(FN_ADDU, 5'd0), a, b);
		issue(r_type(FN_SUB, 5'd0), a, b);
		issue(r_type(FN_SUBU, 5'd0), a, b);
		issue(i_type(OP_ADDI, b[15:0]), a, $urandom);
		issue(i_type(OP_ADDIU, b[15:0]), a, $urandom);
	endtask

	task automatic branch_sweep();
		logic [31:0] x;
		for (int k = 0; k < 8; k++) begin
			x = $urandom;
			// equal, positive, negative and zero rs
			issue(branch_instr(3'(k)), x, x);
			issue(branch_instr(3'(k)), {1'b0, 31'($urandom)} | 32'd1, $urandom);
			issue(branch_instr(3'(k)), {1'b1, 31'($urandom)}, $urandom);
			issue(branch_instr(3'(k)), 32'd0, $urandom);
		end
	endtask

	// out_ready is held high unless back-pressure is on
	initial begin
		out_ready <= 1'b1;
		forever begin
			@(posedge clk);
			if (bp_mode) begin
				out_ready <= 1'($urandom);
			end else begin
				out_ready <= 1'b1;
			end
		end
	end

	// monitor and scoreboard
	always @(posedge clk) begin : monitor
		result_t want;
		int      id;
		int      acc;
		bit      timed;
		cycle_count = cycle_count + 1;
		assert (cycle_count < CYCLE_LIMIT)
		else report_error($sformatf("timeout after %0d cycles, %0d results outstanding",
			cycle_count, model_q.size()));
		if (rst) begin
			model_hi = '0;
			model_lo = '0;
		end else begin
			if (out_valid && out_ready) begin
				assert (model_q.size() != 0)
				else report_error("output transfer with no instruction outstanding");
				want  = model_q.pop_front();
				id    = id_q.pop_front();
				acc   = cycle_q.pop_front();
				timed = timed_q.pop_front();
				assert (out_data == want)
				else report_mismatch(test_name(id), $sformatf("%h", want),
					$sformatf("%h", out_data));
				if (timed) begin
					assert (cycle_count == acc + 2)
					else report_mismatch({test_name(id), " latency"}, "2",
						$sformatf("%0d", cycle_count - acc));
				end
			end
			if (in_valid && in_ready) begin
				want     = predict(in_data.instr, in_data.rs_value, in_data.rt_value,
					model_hi, model_lo);
				model_hi = want.hi;
				model_lo = want.lo;
				model_q.push_back(want);
				id_q.push_back(in_id);
				cycle_q.push_back(cycle_count);
				timed_q.push_back(lat_check);
			end
		end
	end

	initial begin
		void'($urandom(SEED));
		cur_test = T_RESET;
		rst       <= 1'b1;
		in_valid  <= 1'b0;
		in_data   <= '0;
		in_id     <= T_RESET;
		bp_mode   <= 1'b0;
		lat_check <= 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		assert (!out_valid && in_ready)
		else report_error("handshake outputs not in reset state after reset");
		// hi/lo must still read zero here
		issue(r_type(FN_ADDU, 5'd0), $urandom, $urandom);
		issue(hilo_instr(3'd4), $urandom, $urandom);
		issue(r_type(FN_MULT, 5'd0), $urandom, $urandom);

		cur_test = T_ARITH;
		repeat (N_ARITH) issue(arith_instr(), $urandom, $urandom);

		cur_test = T_OVF;
		overflow_pair(32'h7fff_ffff, 32'h0000_0001);
		overflow_pair(32'h8000_0000, 32'hffff_ffff);
		overflow_pair(32'h8000_0000, 32'h0000_0001);
		overflow_pair(32'h7fff_ffff, 32'hffff_ffff);

		cur_test = T_BRANCH;
		branch_sweep();
		for (int k = 0; k < N_UNDEF; k++) begin
			issue(odd_instr(3'(k)), $urandom, $urandom);
		end

		cur_test = T_HILO;
		repeat (N_HILO) issue(hilo_instr(3'($urandom % 5)), $urandom, $urandom);
		drain();

		// random stalls on both sides from here on
		cur_test = T_BACKPR;
		lat_check <= 1'b0;
		bp_mode   <= 1'b1;
		repeat (N_MIXED) begin
			if ($urandom % 4 == 0) begin
				idle_cycles(int'(1 + $urandom % 3));
			end
			issue(mixed_instr(), $urandom, $urandom);
		end
		drain();
		idle_cycles(8);

		if (model_q.size() != 0) begin
			report_error("results still outstanding at end of run");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* compile.f */
src/mips_isa_pkg.sv
src/alu_ctrl_pkg.sv
src/alu_decoder.sv
src/alu_execute.sv
src/alu_result.sv
src/alu_subsystem.sv
tb/tb_clock.sv
tb/alu_subsystem_tb.sv

/* run.sh */
#!/bin/sh
# build and run the ALU slice testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
	--top-module alu_subsystem_tb -f compile.f -o alu_sim

# the log decides pass or fail, so a fatal stop must not end the script here
./obj_dir/alu_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
	echo "run.sh: simulation passed"
else
	echo "run.sh: simulation did not pass"
	exit 1
fi
